// File: psg_reg_pkg.sv
package psg_reg_pkg;

	// write address register field
	parameter int REG_SEL_W = 3;

	// per-channel register fields
	parameter int FREQ_W = 16;
	// table length is 2 << len_log2 samples
	parameter int LEN_W = 3;
	parameter int VOL_W = 4;

	// register selector, one opcode per channel register
	typedef enum logic [REG_SEL_W-1:0] {
		REG_FREQ = 3'd0,
		REG_BASE = 3'd1,
		REG_LEN  = 3'd2,
		REG_VOL  = 3'd3,
		REG_CTRL = 3'd4
	} psg_reg_e;

endpackage

// File: psg_bus_pkg.sv
package psg_bus_pkg;

	// system memory port
	parameter int ADDR_W = 16;
	parameter int SAMPLE_W = 8;

	// phase accumulator, top bits form the table index
	parameter int PHASE_W = 24;

	// memory read sequencer
	typedef enum logic [1:0] {
		// bus free, waiting for a granted request
		BM_IDLE    = 2'd0,
		// mem_rd held until mem_ack
		BM_READ    = 2'd1,
		// sample_we to the channel that asked
		BM_DELIVER = 2'd2
	} bm_state_e;

endpackage

// File: psg_ctrl.sv
module psg_ctrl
	import psg_reg_pkg::*, psg_bus_pkg::*;
#(
	parameter int NUM_CHAN = 4,
	parameter int CE_DIV = 4,
	parameter int TICK_DIV = 64,
	localparam int CHAN_W = $clog2(NUM_CHAN)
) (
	input  logic clk,
	input  logic rst,
	input  logic wr_en,
	input  logic [CHAN_W-1:0] wr_chan,
	input  psg_reg_e wr_sel,
	input  logic [FREQ_W-1:0] wr_data,
	output logic [NUM_CHAN-1:0][FREQ_W-1:0] freq,
	output logic [NUM_CHAN-1:0][ADDR_W-1:0] base,
	output logic [NUM_CHAN-1:0][LEN_W-1:0] len_log2,
	output logic [NUM_CHAN-1:0][VOL_W-1:0] vol,
	output logic [NUM_CHAN-1:0] en,
	output logic ce,
	output logic tick
);

	localparam int CE_CNT_W = $clog2(CE_DIV);
	localparam int TICK_CNT_W = $clog2(TICK_DIV);

	logic [CE_CNT_W-1:0] ce_cnt;
	logic [TICK_CNT_W-1:0] tick_cnt;

	// ==========================================================
	// register file
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= '0;
			base <= '0;
			len_log2 <= '0;
			vol <= '0;
			en <= '0;
		end else if (wr_en) begin
			case (wr_sel)
				REG_FREQ: freq[wr_chan] <= wr_data;
				REG_BASE: base[wr_chan] <= wr_data[ADDR_W-1:0];
				REG_LEN:  len_log2[wr_chan] <= wr_data[LEN_W-1:0];
				REG_VOL:  vol[wr_chan] <= wr_data[VOL_W-1:0];
				// bit 0 is the channel enable
				REG_CTRL: en[wr_chan] <= wr_data[0];
				default: ;
			endcase
		end
	end

	// ==========================================================
	// clock enable and sample tick
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			ce_cnt <= '0;
			tick_cnt <= '0;
			ce <= 1'b0;
			tick <= 1'b0;
		end else begin
			ce <= 1'b0;
			tick <= 1'b0;
			if (ce_cnt == CE_CNT_W'(CE_DIV - 1)) begin
				ce_cnt <= '0;
				ce <= 1'b1;
				// tick always lands on a ce cycle
				if (tick_cnt == TICK_CNT_W'(TICK_DIV - 1)) begin
					tick_cnt <= '0;
					tick <= 1'b1;
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end else begin
				ce_cnt <= ce_cnt + 1'b1;
			end
		end
	end

endmodule

// File: psg_bus_arb.sv
module psg_bus_arb #(
	parameter int NUM_CHAN = 4,
	localparam int CHAN_W = $clog2(NUM_CHAN)
) (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic bus_free,
	input  logic [NUM_CHAN-1:0] req,
	output logic [NUM_CHAN-1:0] sel,
	output logic [CHAN_W-1:0] seln
);

	logic any_req;
	logic [CHAN_W-1:0] win_n;
	logic [NUM_CHAN-1:0] win_sel;

	// lowest numbered requester wins, channel 0 first
	always_comb begin
		any_req = |req;
		win_n = '0;
		win_sel = '0;
		for (int i = NUM_CHAN - 1; i >= 0; i--) begin
			if (req[i]) begin
				win_n = CHAN_W'(i);
				win_sel = NUM_CHAN'(1) << i;
			end
		end
	end

	// grant moves only on a ce edge with the bus idle
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (ce && bus_free && any_req) begin
			sel <= win_sel;
			seln <= win_n;
		end
		// with no request the last owner keeps the grant
	end

endmodule

// File: psg_wave_chan.sv
module psg_wave_chan
	import psg_reg_pkg::*, psg_bus_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic tick,
	input  logic en,
	input  logic [FREQ_W-1:0] freq,
	input  logic [ADDR_W-1:0] base,
	input  logic [LEN_W-1:0] len_log2,
	input  logic sample_we,
	input  logic [SAMPLE_W-1:0] sample_in,
	output logic req,
	output logic [ADDR_W-1:0] addr,
	output logic [SAMPLE_W-1:0] sample
);

	// table index is at most eight bits wide
	localparam int IDX_W = 8;

	logic [PHASE_W-1:0] phase;
	logic [PHASE_W-1:0] phase_nxt;
	logic [IDX_W-1:0] idx_mask;
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] idx_nxt;
	logic en_q;

	always_comb begin
		phase_nxt = phase + PHASE_W'(freq);
		// 2 << len_log2 entries
		idx_mask = {IDX_W{1'b1}} >> (LEN_W'(IDX_W - 1) - len_log2);
		idx = phase[PHASE_W-1 -: IDX_W] & idx_mask;
		idx_nxt = phase_nxt[PHASE_W-1 -: IDX_W] & idx_mask;
		addr = base + ADDR_W'(idx);
	end

	// ==========================================================
	// phase and fetch request
	// ==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
			en_q <= 1'b0;
			req <= 1'b0;
		end else begin
			en_q <= en;
			if (!en) begin
				phase <= '0;
				req <= 1'b0;
			end else begin
				if (tick)
					phase <= phase_nxt;
				// a new index or a fresh enable needs a fetch
				if ((tick && idx_nxt != idx) || !en_q)
					req <= 1'b1;
				else if (sample_we)
					req <= 1'b0;
			end
		end
	end

	// last byte returned by the bus master
	always_ff @(posedge clk) begin
		if (sample_we)
			sample <= sample_in;
	end

endmodule

// File: psg_bus_master.sv
module psg_bus_master
	import psg_bus_pkg::*;
#(
	parameter int NUM_CHAN = 4,
	localparam int CHAN_W = $clog2(NUM_CHAN)
) (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic [NUM_CHAN-1:0] req,
	input  logic [CHAN_W-1:0] seln,
	input  logic [NUM_CHAN-1:0][ADDR_W-1:0] addr,
	input  logic mem_ack,
	input  logic [SAMPLE_W-1:0] mem_data,
	output logic mem_rd,
	output logic [ADDR_W-1:0] mem_addr,
	output logic bus_free,
	output logic [NUM_CHAN-1:0] sample_we,
	output logic [SAMPLE_W-1:0] sample_data
);

	bm_state_e state;
	logic [CHAN_W-1:0] cur_chan;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= BM_IDLE;
			cur_chan <= '0;
		end else begin
			case (state)
				BM_IDLE:
					if (ce && req[seln]) begin
						cur_chan <= seln;
						state <= BM_READ;
					end
				BM_READ:
					if (mem_ack)
						state <= BM_DELIVER;
				default:
					state <= BM_IDLE;
			endcase
		end
	end

	// address and data path
	always_ff @(posedge clk) begin
		if (state == BM_IDLE && ce && req[seln])
			mem_addr <= addr[seln];
		if (state == BM_READ && mem_ack)
			sample_data <= mem_data;
	end

	always_comb begin
		mem_rd = (state == BM_READ);
		bus_free = (state == BM_IDLE);
		sample_we = '0;
		if (state == BM_DELIVER)
			sample_we[cur_chan] = 1'b1;
	end

endmodule

// File: psg_mixer.sv
module psg_mixer
	import psg_reg_pkg::*, psg_bus_pkg::*;
#(
	parameter int NUM_CHAN = 4,
	parameter int AUDIO_W = 14
) (
	input  logic clk,
	input  logic rst,
	input  logic tick,
	input  logic [NUM_CHAN-1:0] en,
	input  logic [NUM_CHAN-1:0][VOL_W-1:0] vol,
	input  logic [NUM_CHAN-1:0][SAMPLE_W-1:0] sample,
	output logic signed [AUDIO_W-1:0] audio_out,
	output logic audio_valid
);

	// signed sample times volume with a zero sign bit
	localparam int PROD_W = SAMPLE_W + VOL_W + 1;

	logic signed [PROD_W-1:0] prod [NUM_CHAN];
	logic signed [AUDIO_W-1:0] mix;

	always_comb begin
		mix = '0;
		for (int i = 0; i < NUM_CHAN; i++) begin
			prod[i] = $signed(sample[i]) * $signed({1'b0, vol[i]});
			if (en[i])
				mix = mix + AUDIO_W'(prod[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			audio_out <= '0;
			audio_valid <= 1'b0;
		end else begin
			audio_valid <= tick;
			if (tick)
				audio_out <= mix;
		end
	end

endmodule

// File: psg_wave_top.sv
module psg_wave_top
	import psg_reg_pkg::*, psg_bus_pkg::*;
#(
	parameter int NUM_CHAN = 4,
	parameter int CE_DIV = 4,
	parameter int TICK_DIV = 64,
	localparam int CHAN_W = $clog2(NUM_CHAN),
	localparam int AUDIO_W = SAMPLE_W + VOL_W + CHAN_W
) (
	input  logic clk,
	input  logic rst,
	input  logic wr_en,
	input  logic [CHAN_W-1:0] wr_chan,
	input  psg_reg_e wr_sel,
	input  logic [FREQ_W-1:0] wr_data,
	output logic mem_rd,
	output logic [ADDR_W-1:0] mem_addr,
	input  logic mem_ack,
	input  logic [SAMPLE_W-1:0] mem_data,
	output logic signed [AUDIO_W-1:0] audio_out,
	output logic audio_valid
);

	logic [NUM_CHAN-1:0][FREQ_W-1:0] freq;
	logic [NUM_CHAN-1:0][ADDR_W-1:0] base;
	logic [NUM_CHAN-1:0][LEN_W-1:0] len_log2;
	logic [NUM_CHAN-1:0][VOL_W-1:0] vol;
	logic [NUM_CHAN-1:0] en;
	logic ce;
	logic tick;

	logic [NUM_CHAN-1:0] req;
	logic [NUM_CHAN-1:0][ADDR_W-1:0] addr;
	logic [NUM_CHAN-1:0][SAMPLE_W-1:0] sample;
	logic [NUM_CHAN-1:0] sample_we;
	logic [SAMPLE_W-1:0] sample_data;

	logic [CHAN_W-1:0] seln;
	logic bus_free;

	psg_ctrl #(
		.NUM_CHAN(NUM_CHAN),
		.CE_DIV(CE_DIV),
		.TICK_DIV(TICK_DIV)
	) u_ctrl (
		.clk(clk), .rst(rst),
		.wr_en(wr_en), .wr_chan(wr_chan), .wr_sel(wr_sel), .wr_data(wr_data),
		.freq(freq), .base(base), .len_log2(len_log2), .vol(vol), .en(en),
		.ce(ce), .tick(tick)
	);

	// ==========================================================
	// wave table channels
	// ==========================================================
	for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
		psg_wave_chan u_chan (
			.clk(clk), .rst(rst), .tick(tick), .en(en[i]),
			.freq(freq[i]), .base(base[i]), .len_log2(len_log2[i]),
			.sample_we(sample_we[i]), .sample_in(sample_data),
			.req(req[i]), .addr(addr[i]), .sample(sample[i])
		);
	end

	psg_bus_arb #(.NUM_CHAN(NUM_CHAN)) u_arb (
		.clk(clk), .rst(rst), .ce(ce), .bus_free(bus_free),
		.req(req), .sel(), .seln(seln)
	);

	psg_bus_master #(.NUM_CHAN(NUM_CHAN)) u_bm (
		.clk(clk), .rst(rst), .ce(ce), .req(req), .seln(seln), .addr(addr),
		.mem_ack(mem_ack), .mem_data(mem_data), .mem_rd(mem_rd), .mem_addr(mem_addr),
		.bus_free(bus_free), .sample_we(sample_we), .sample_data(sample_data)
	);

	psg_mixer #(.NUM_CHAN(NUM_CHAN), .AUDIO_W(AUDIO_W)) u_mixer (
		.clk(clk), .rst(rst), .tick(tick), .en(en), .vol(vol), .sample(sample),
		.audio_out(audio_out), .audio_valid(audio_valid)
	);

endmodule

// File: tb_psg_wave.sv
module tb_psg_wave
	import psg_reg_pkg::*, psg_bus_pkg::*;
();

	localparam int NUM_CHAN = 4;
	localparam int CE_DIV = 4;
	localparam int TICK_DIV = 64;
	localparam int CLK_PERIOD = 10;
	localparam int AUDIO_W = SAMPLE_W + VOL_W + 2;
	localparam int TICK_CYCLES = TICK_DIV * CE_DIV;
	// ticks of the five tests, plus the first one after reset
	localparam int TEST_TICKS = 8 + 20 + 16 + 24 + 9 + 1;

	logic clk;
	logic rst;
	logic wr_en;
	logic [1:0] wr_chan;
	psg_reg_e wr_sel;
	logic [FREQ_W-1:0] wr_data;
	logic mem_rd;
	logic [ADDR_W-1:0] mem_addr;
	logic mem_ack = 1'b0;
	logic [SAMPLE_W-1:0] mem_data = '0;
	logic signed [AUDIO_W-1:0] audio_out;
	logic audio_valid;

	// reference model, one entry per channel
	logic [FREQ_W-1:0] m_freq [NUM_CHAN];
	logic [ADDR_W-1:0] m_base [NUM_CHAN];
	logic [LEN_W-1:0] m_len [NUM_CHAN];
	logic [VOL_W-1:0] m_vol [NUM_CHAN];
	logic m_en [NUM_CHAN];
	logic [PHASE_W-1:0] m_phase [NUM_CHAN];

	int mismatch_count = 0;
	int fail_count = 0;

	// memory model state
	logic [31:0] rand_state = 32'hcffd;
	logic mem_busy = 1'b0;
	int mem_wait = 0;
	logic [ADDR_W-1:0] mem_hold_addr = '0;
	logic [ADDR_W-1:0] last_addr = '0;
	int rd_starts = 0;
	int mem_errors = 0;

	psg_wave_top #(
		.NUM_CHAN(NUM_CHAN),
		.CE_DIV(CE_DIV),
		.TICK_DIV(TICK_DIV)
	) UUT (
		.clk(clk), .rst(rst),
		.wr_en(wr_en), .wr_chan(wr_chan), .wr_sel(wr_sel), .wr_data(wr_data),
		.mem_rd(mem_rd), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_data(mem_data),
		.audio_out(audio_out), .audio_valid(audio_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TEST_TICKS * TICK_CYCLES * 2 * CLK_PERIOD);
		$display("watchdog expired, tests not finished at %0t", $time);
		$display("TESTS FAILED");
		$finish;
	end

	// ==========================================================
	// reference rules
	// ==========================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// memory content is the low address byte XOR 0x5A
	function automatic logic [SAMPLE_W-1:0] mem_byte(input logic [ADDR_W-1:0] a);
		return a[7:0] ^ 8'h5a;
	endfunction

	function automatic int table_size(input logic [LEN_W-1:0] len);
		return 2 << len;
	endfunction

	function automatic logic [7:0] table_index(input logic [PHASE_W-1:0] ph,
		input logic [LEN_W-1:0] len);
		return ph[PHASE_W-1 -: 8] & 8'(table_size(len) - 1);
	endfunction

	function automatic int expected_mix();
		int sum;
		logic [ADDR_W-1:0] a;
		sum = 0;
		for (int i = 0; i < NUM_CHAN; i++) begin
			if (m_en[i]) begin
				a = m_base[i] + ADDR_W'(table_index(m_phase[i], m_len[i]));
				sum += int'($signed(mem_byte(a))) * int'(m_vol[i]);
			end
		end
		return sum;
	endfunction

	// ==========================================================
	// memory model, driven on the falling edge
	// ==========================================================
	always @(negedge clk) begin
		if (rst) begin
			mem_ack = 1'b0;
			mem_busy = 1'b0;
		end else if (mem_ack) begin
			mem_ack = 1'b0;
			mem_busy = 1'b0;
		end else if (mem_rd) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				mem_hold_addr = mem_addr;
				rand_state = xorshift32(rand_state);
				mem_wait = 1 + int'(rand_state[2:0]);
				rd_starts++;
			end else if (mem_addr !== mem_hold_addr) begin
				$display("memory address changed during a pending read at %0t", $time);
				mem_errors++;
			end
			mem_wait--;
			if (mem_wait == 0) begin
				mem_ack = 1'b1;
				mem_data = mem_byte(mem_addr);
				last_addr = mem_addr;
			end
		end
	end

	// ==========================================================
	// helper tasks
	// ==========================================================
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name,
				$signed(got), $signed(exp));
			mismatch_count++;
		end
	endtask

	task automatic write_reg(input int chan, input psg_reg_e sel, input logic [15:0] data);
		wr_en = 1'b1;
		wr_chan = 2'(chan);
		wr_sel = sel;
		wr_data = data;
		case (sel)
			REG_FREQ: m_freq[chan] = data;
			REG_BASE: m_base[chan] = data;
			REG_LEN:  m_len[chan] = data[LEN_W-1:0];
			REG_VOL:  m_vol[chan] = data[VOL_W-1:0];
			REG_CTRL: begin
				m_en[chan] = data[0];
				// a disabled channel restarts from phase 0
				if (!data[0])
					m_phase[chan] = '0;
			end
			default: ;
		endcase
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic setup_chan(input int chan, input logic [15:0] freq,
		input logic [15:0] base, input logic [2:0] len, input logic [3:0] vol);
		write_reg(chan, REG_FREQ, freq);
		write_reg(chan, REG_BASE, base);
		write_reg(chan, REG_LEN, 16'(len));
		write_reg(chan, REG_VOL, 16'(vol));
		write_reg(chan, REG_CTRL, 16'd1);
	endtask

	task automatic wait_audio_valid();
		int n;
		n = 0;
		@(negedge clk);
		while (audio_valid !== 1'b1 && n < TICK_CYCLES + 16) begin
			@(negedge clk);
			n++;
		end
		if (audio_valid !== 1'b1) begin
			$display("audio_valid did not pulse within %0d cycles, at %0t", n, $time);
			fail_count++;
		end
	endtask

	// one sample tick: check the mix, optionally the last read address, then advance
	task automatic step_tick(input int addr_chan);
		int lo;
		int hi;
		wait_audio_valid();
		check_value("audio_out", 32'(audio_out), expected_mix());
		if (addr_chan >= 0) begin
			lo = int'(m_base[addr_chan]);
			hi = lo + table_size(m_len[addr_chan]);
			check_value("mem_addr", 32'(last_addr), 32'(m_base[addr_chan]
				+ ADDR_W'(table_index(m_phase[addr_chan], m_len[addr_chan]))));
			check_value("mem_addr_in_table",
				32'(int'(last_addr) >= lo && int'(last_addr) < hi), 32'd1);
		end
		for (int i = 0; i < NUM_CHAN; i++)
			if (m_en[i])
				m_phase[i] = m_phase[i] + PHASE_W'(m_freq[i]);
	endtask

	// ==========================================================
	// tests
	// ==========================================================
	task automatic idle_after_reset();
		for (int k = 0; k < 8; k++)
			step_tick(-1);
		check_value("read_count", rd_starts, 0);
	endtask

	task automatic single_channel_fetch();
		setup_chan(1, 16'hc000, 16'h1230, 3'd7, 4'd11);
		for (int k = 0; k < 20; k++)
			step_tick(1);
	endtask

	// four entries, index steps almost one per tick and wraps
	task automatic table_wrap();
		write_reg(1, REG_CTRL, 16'd0);
		setup_chan(2, 16'hffff, 16'h20fc, 3'd1, 4'd7);
		for (int k = 0; k < 16; k++)
			step_tick(2);
	endtask

	task automatic four_channel_mix();
		write_reg(2, REG_CTRL, 16'd0);
		setup_chan(0, 16'h9000, 16'h0100, 3'd7, 4'd15);
		setup_chan(1, 16'he123, 16'h0340, 3'd5, 4'd9);
		setup_chan(2, 16'h7777, 16'h8000, 3'd3, 4'd4);
		setup_chan(3, 16'hffff, 16'hf0f0, 3'd6, 4'd12);
		for (int k = 0; k < 24; k++)
			step_tick(-1);
	endtask

	task automatic volume_and_disable();
		write_reg(0, REG_VOL, 16'd3);
		step_tick(-1);
		step_tick(-1);
		write_reg(1, REG_CTRL, 16'd0);
		step_tick(-1);
		step_tick(-1);
		write_reg(3, REG_VOL, 16'd0);
		write_reg(2, REG_VOL, 16'd15);
		step_tick(-1);
		write_reg(0, REG_CTRL, 16'd0);
		write_reg(2, REG_CTRL, 16'd0);
		step_tick(-1);
		// re-enable fetches index 0 again
		write_reg(1, REG_CTRL, 16'd1);
		for (int k = 0; k < 3; k++)
			step_tick(-1);
	endtask

	initial begin
		rst = 1'b1;
		wr_en = 1'b0;
		wr_chan = '0;
		wr_sel = REG_FREQ;
		wr_data = '0;
		for (int i = 0; i < NUM_CHAN; i++) begin
			m_freq[i] = '0;
			m_base[i] = '0;
			m_len[i] = '0;
			m_vol[i] = '0;
			m_en[i] = 1'b0;
			m_phase[i] = '0;
		end
		repeat (3) @(negedge clk);
		rst = 1'b0;

		idle_after_reset();
		single_channel_fetch();
		table_wrap();
		four_channel_mix();
		volume_and_disable();

		$display("errors: %0d mismatches, %0d other failures", mismatch_count,
			fail_count + mem_errors);
		if (mismatch_count == 0 && fail_count + mem_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: psg_wave.f
psg_reg_pkg.sv
psg_bus_pkg.sv
psg_ctrl.sv
psg_bus_arb.sv
psg_wave_chan.sv
psg_bus_master.sv
psg_mixer.sv
psg_wave_top.sv
tb_psg_wave.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --top-module tb_psg_wave -f psg_wave.f &&
	out=$(./obj_dir/Vtb_psg_wave) &&
	printf '%s\n' "$out" &&
	printf '%s\n' "$out" | grep -q "TESTS PASSED" ||
	{ echo "simulation failed"; exit 1; }
echo "simulation passed"
